// ==== eeprom_bus_pkg.sv ====
package eeprom_bus_pkg;

    // quarters per bus symbol
    localparam int QUARTERS = 4;

    // fixed upper nibble of the select byte
    localparam logic [3:0] DEV_CODE = 4'b1010;

    // one symbol on scl/sda
    typedef enum logic [1:0] {
        op_start = 2'd0,
        op_stop  = 2'd1,
        op_write = 2'd2,
        op_read  = 2'd3
    } bit_op_e;

    typedef struct packed {
        bit_op_e op;
        logic    sbit;    // level to send on op_write
    } bit_cmd_t;

endpackage

// ==== eeprom_host_pkg.sv ====
package eeprom_host_pkg;

    localparam int ADDR_W = 11;
    localparam int DATA_W = 8;

    // captured on a wr or rd strobe
    typedef struct packed {
        logic              write;   // 0 means random read
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } host_req_t;

    // valid with ack, held until the next one
    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              nack;    // device refused a byte
    } host_rsp_t;

endpackage

// ==== byte_shifter.sv ====
`timescale 1ns/1ps

module byte_shifter (
    input  logic       CLK,
    input  logic       RESET,
    input  logic       load,
    input  logic       shift,
    input  logic [7:0] load_byte,
    input  logic       sin,
    output logic       msb,
    output logic       last_bit,
    output logic [7:0] shift_byte
);
    logic [7:0] sreg;
    logic [2:0] bit_cnt;   // bit now on the wire

    // same register for send and receive
    always_ff @(posedge CLK)
    begin
        if (load)
            sreg <= load_byte;
        else if (shift)
            sreg <= {sreg[6:0], sin};   // out at the top, in at the bottom
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
            bit_cnt <= '0;
        else if (load)
            bit_cnt <= '0;
        else if (shift)
            bit_cnt <= bit_cnt + 3'd1;   // wraps after the eighth bit
    end

    assign msb        = sreg[7];
    assign last_bit   = (bit_cnt == 3'd7);
    assign shift_byte = sreg;

endmodule

// ==== bit_engine.sv ====
`timescale 1ns/1ps

module bit_engine #(
    parameter int CLKS_PER_QUARTER = 2
) (
    input  logic                     CLK,
    input  logic                     RESET,
    input  logic                     cmd_valid,
    input  eeprom_bus_pkg::bit_cmd_t cmd,
    output logic                     bit_done,
    output logic                     rbit,
    output logic                     scl,
    output logic                     sda_low,
    input  logic                     sda_in
);
    import eeprom_bus_pkg::*;

    localparam int         QW         = $clog2(CLKS_PER_QUARTER + 1);
    localparam logic [1:0] LAST_PHASE = 2'(QUARTERS - 1);

    bit_cmd_t      cur;
    logic          busy;
    logic [1:0]    phase;
    logic [QW-1:0] qcnt;
    logic          q_end;

    if (CLKS_PER_QUARTER < 1)
    begin : g_bad_rate
        $error("CLKS_PER_QUARTER must be at least 1");
    end

    // {scl, sda_low} for a given quarter of a symbol
    function automatic logic [1:0] pin_levels(bit_cmd_t c, logic [1:0] ph);
        logic scl_v;
        logic low_v;
        scl_v = (ph == 2'd1) || (ph == 2'd2);
        case (c.op)
            op_start: low_v = ph[1];   // falls in quarter 2 while scl is high
            op_stop:
            begin
                scl_v = (ph != 2'd0);
                low_v = !ph[1];        // rises in quarter 2
            end
            op_write: low_v = !c.sbit;
            default:  low_v = 1'b0;    // read bit leaves sda to the slave
        endcase
        return {scl_v, low_v};
    endfunction

    assign q_end    = (qcnt == QW'(CLKS_PER_QUARTER - 1));
    assign bit_done = busy && q_end && (phase == LAST_PHASE);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy    <= 1'b0;
            phase   <= '0;
            qcnt    <= '0;
            cur     <= '{op: op_stop, sbit: 1'b1};
            scl     <= 1'b1;   // bus idle
            sda_low <= 1'b0;
        end
        else if (!busy)
        begin
            if (cmd_valid)
            begin
                busy           <= 1'b1;
                cur            <= cmd;
                phase          <= '0;
                qcnt           <= '0;
                {scl, sda_low} <= pin_levels(cmd, 2'd0);
            end
        end
        else if (q_end)
        begin
            qcnt <= '0;
            if (phase == LAST_PHASE)
                busy <= 1'b0;   // pins hold until the next symbol
            else
            begin
                phase          <= phase + 2'd1;
                {scl, sda_low} <= pin_levels(cur, phase + 2'd1);
            end
        end
        else
            qcnt <= qcnt + 1'b1;
    end

    // mid-high sample
    always_ff @(posedge CLK)
    begin
        if (busy && cur.op == op_read && phase == 2'd1 && q_end)
            rbit <= sda_in;
    end

    assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && $changed(sda_low)) |-> (cur.op inside {op_start, op_stop}));

endmodule

// ==== eeprom_ctrl.sv ====
`timescale 1ns/1ps

module eeprom_ctrl (
    input  logic                       CLK,
    input  logic                       RESET,
    input  logic                       wr,
    input  logic                       rd,
    input  eeprom_host_pkg::host_req_t req,
    output logic                       ack,
    output eeprom_host_pkg::host_rsp_t rsp,
    output logic                       cmd_valid,
    output eeprom_bus_pkg::bit_cmd_t   cmd,
    input  logic                       bit_done,
    input  logic                       rbit,
    output logic                       load,
    output logic                       shift,
    output logic [7:0]                 load_byte,
    input  logic                       msb,
    input  logic                       last_bit,
    input  logic [7:0]                 shift_byte
);
    import eeprom_bus_pkg::*;
    import eeprom_host_pkg::*;

    typedef enum logic [3:0] {
        st_idle,
        st_start,
        st_select,
        st_address,
        st_data_out,
        st_rstart,
        st_select_rd,
        st_data_in,
        st_ack,
        st_stop
    } state_e;

    state_e    state;
    state_e    ret_state;   // where to go once the ack bit is through
    state_e    ret_next;
    host_req_t req_q;
    logic      send;        // shifter msb is ready to go out
    logic      pending;     // a command is out at the bit engine
    logic      nack_q;
    logic      dev_nack;

    // only a read symbol carries the device answer
    assign dev_nack = (cmd.op == op_read) && rbit;

    always_comb
    begin
        case (state)
            st_address:   ret_next = req_q.write ? st_data_out : st_rstart;
            st_data_out:  ret_next = st_stop;
            st_select_rd: ret_next = st_data_in;
            default:      ret_next = st_address;
        endcase
    end

    // shifter strobes follow bit_done in the same cycle
    always_comb
    begin
        load      = 1'b0;
        load_byte = 8'hff;
        shift     = bit_done && (state inside {st_select, st_address, st_data_out,
                                               st_select_rd, st_data_in});
        if (bit_done)
        begin
            case (state)
                st_start:
                begin
                    load      = 1'b1;
                    load_byte = {DEV_CODE, req_q.addr[10:8], 1'b0};
                end
                st_rstart:
                begin
                    load      = 1'b1;
                    load_byte = {DEV_CODE, req_q.addr[10:8], 1'b1};
                end
                st_ack:
                begin
                    load = !dev_nack && (ret_state inside {st_address, st_data_out, st_data_in});
                    if (ret_state == st_address)
                        load_byte = req_q.addr[7:0];
                    else if (ret_state == st_data_out)
                        load_byte = req_q.wdata;
                end
                default: load = 1'b0;
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        logic     go;
        bit_cmd_t nxt;
        go  = 1'b0;
        nxt = cmd;
        if (RESET)
        begin
            state     <= st_idle;
            ret_state <= st_idle;
            send      <= 1'b0;
            pending   <= 1'b0;
            nack_q    <= 1'b0;
            ack       <= 1'b0;
            rsp       <= '0;
            cmd_valid <= 1'b0;
            cmd       <= '{op: op_stop, sbit: 1'b1};
        end
        else
        begin
            ack     <= 1'b0;
            pending <= pending && !bit_done;
            case (state)
                st_idle:
                    if (wr || rd)   // wr wins, req.write carries it
                    begin
                        req_q  <= req;
                        nack_q <= 1'b0;
                        state  <= st_start;
                        go     = 1'b1;
                        nxt    = '{op_start, 1'b1};
                    end
                st_start, st_rstart:
                    if (bit_done)
                    begin
                        state <= (state == st_start) ? st_select : st_select_rd;
                        send  <= 1'b1;
                    end
                st_select, st_address, st_data_out, st_select_rd:
                    if (send)
                    begin
                        send <= 1'b0;
                        go   = 1'b1;
                        nxt  = '{op_write, msb};
                    end
                    else if (bit_done && last_bit)
                    begin
                        state     <= st_ack;
                        ret_state <= ret_next;
                        go        = 1'b1;
                        nxt       = '{op_read, 1'b1};   // release for device ack
                    end
                    else if (bit_done)
                        send <= 1'b1;
                st_data_in:
                    if (bit_done)
                    begin
                        go = 1'b1;
                        if (last_bit)
                        begin
                            state     <= st_ack;
                            ret_state <= st_stop;
                            nxt       = '{op_write, 1'b1};   // master nack
                        end
                        else
                            nxt = '{op_read, 1'b1};
                    end
                st_ack:
                    if (bit_done)
                    begin
                        if (dev_nack)
                        begin
                            nack_q <= 1'b1;
                            state  <= st_stop;
                            go     = 1'b1;
                            nxt    = '{op_stop, 1'b0};
                        end
                        else
                        begin
                            case (ret_state)
                                st_address, st_data_out:
                                begin
                                    state <= ret_state;
                                    send  <= 1'b1;
                                end
                                st_rstart, st_data_in:
                                begin
                                    state <= ret_state;
                                    go    = 1'b1;
                                    nxt   = (ret_state == st_rstart) ? '{op_start, 1'b1}
                                                                     : '{op_read, 1'b1};
                                end
                                default:
                                begin
                                    state <= st_stop;
                                    go    = 1'b1;
                                    nxt   = '{op_stop, 1'b0};
                                end
                            endcase
                        end
                    end
                st_stop:
                    if (bit_done)
                    begin
                        state    <= st_idle;
                        ack      <= 1'b1;
                        rsp.nack <= nack_q;
                        if (!req_q.write && !nack_q)
                            rsp.rdata <= shift_byte;
                    end
                default: state <= st_idle;
            endcase
            cmd_valid <= go;
            if (go)
            begin
                cmd     <= nxt;
                pending <= 1'b1;
            end
        end
    end

    // next command only once the engine reported the last one
    assert property (@(posedge CLK) disable iff (RESET)
        cmd_valid |-> $past(!pending || bit_done));

    assert property (@(posedge CLK) disable iff (RESET) ack |=> !ack);

endmodule

// ==== eeprom_wr.sv ====
`timescale 1ns/1ps

module eeprom_wr #(
    parameter int CLKS_PER_QUARTER = 2
) (
    input  logic        CLK,
    input  logic        RESET,
    input  logic        wr,
    input  logic        rd,
    input  logic [10:0] addr,
    input  logic [7:0]  wdata,
    output logic [7:0]  rdata,
    output logic        ack,
    output logic        nack,
    output logic        scl,
    inout  wire         sda
);
    import eeprom_bus_pkg::*;
    import eeprom_host_pkg::*;

    host_req_t  req;
    host_rsp_t  rsp;
    bit_cmd_t   cmd;
    logic       cmd_valid;
    logic       bit_done;
    logic       rbit;
    logic       sda_low;
    logic       load;
    logic       shift;
    logic [7:0] load_byte;
    logic       msb;
    logic       last_bit;
    logic [7:0] shift_byte;

    assign req   = '{write: wr, addr: addr, wdata: wdata};
    assign rdata = rsp.rdata;
    assign nack  = rsp.nack;

    // open drain, pullup sits outside
    assign sda = sda_low ? 1'b0 : 1'bz;

    eeprom_ctrl ctrl_i (
        .CLK        (CLK),
        .RESET      (RESET),
        .wr         (wr),
        .rd         (rd),
        .req        (req),
        .ack        (ack),
        .rsp        (rsp),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .bit_done   (bit_done),
        .rbit       (rbit),
        .load       (load),
        .shift      (shift),
        .load_byte  (load_byte),
        .msb        (msb),
        .last_bit   (last_bit),
        .shift_byte (shift_byte)
    );

    bit_engine #(
        .CLKS_PER_QUARTER (CLKS_PER_QUARTER)
    ) bit_i (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .bit_done  (bit_done),
        .rbit      (rbit),
        .scl       (scl),
        .sda_low   (sda_low),
        .sda_in    (sda)
    );

    byte_shifter shift_i (
        .CLK        (CLK),
        .RESET      (RESET),
        .load       (load),
        .shift      (shift),
        .load_byte  (load_byte),
        .sin        (rbit),   // received bit from the engine
        .msb        (msb),
        .last_bit   (last_bit),
        .shift_byte (shift_byte)
    );

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PERIOD_NS    = 8.0,
    parameter int  RESET_CYCLES = 2
) (
    output logic CLK,
    output logic RESET
);
    initial
    begin
        CLK   = 1'b0;
        RESET = 1'b1;
        repeat (RESET_CYCLES) @(posedge CLK);
        RESET <= 1'b0;   // released on an edge, seen by the DUT one edge later
    end

    always #(PERIOD_NS / 2.0) CLK = ~CLK;

endmodule

// ==== eeprom_model.sv ====
`timescale 1ns/1ps

module eeprom_model (
    input  logic scl,
    inout  wire  sda,
    input  logic present
);
    typedef enum {m_idle, m_dev, m_addr, m_wdata, m_rdata} mstate_e;

    logic [7:0]  mem [0:2047];
    mstate_e     state;
    mstate_e     next_state;   // taken after our ack clock
    logic [7:0]  shreg;
    logic [10:0] ptr;
    int          bit_cnt;      // clocks seen in the current byte
    logic        acking;
    logic        drive_low;

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial
    begin
        state      = m_idle;
        next_state = m_idle;
        bit_cnt    = 0;
        acking     = 1'b0;
        drive_low  = 1'b0;
    end

    // a full byte came in, decide whether to ack it
    task automatic take_byte();
        case (state)
            m_dev:
                if (present && shreg[7:4] == 4'b1010)
                begin
                    ptr[10:8]  = shreg[3:1];   // block bits of the 24C16 select byte
                    next_state = shreg[0] ? m_rdata : m_addr;
                end
                else
                    state = m_idle;   // not us, stay off the bus
            m_addr:
            begin
                ptr[7:0]   = shreg;
                next_state = m_wdata;
            end
            default:
            begin
                mem[ptr]   = shreg;
                next_state = m_idle;   // single byte writes only
            end
        endcase
    endtask

    // start or repeated start
    always @(negedge sda)
    begin
        if (scl === 1'b1)
        begin
            state     = m_dev;
            bit_cnt   = 0;
            acking    = 1'b0;
            drive_low = 1'b0;
        end
    end

    // stop
    always @(posedge sda)
    begin
        if (scl === 1'b1)
        begin
            state     = m_idle;
            acking    = 1'b0;
            drive_low = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        if (state == m_rdata)
        begin
            if (bit_cnt == 8)
                state = m_idle;   // master ack clock ends the read
            bit_cnt = bit_cnt + 1;
        end
        else if (state != m_idle && bit_cnt < 8)
        begin
            shreg   = {shreg[6:0], sda !== 1'b0};
            bit_cnt = bit_cnt + 1;
            if (bit_cnt == 8)
                take_byte();
        end
    end

    // sda only moves while scl is low
    always @(negedge scl)
    begin
        if (acking)
        begin
            acking    = 1'b0;
            drive_low = 1'b0;
            bit_cnt   = 0;
            state     = next_state;
            if (state == m_rdata)
            begin
                shreg     = mem[ptr];
                drive_low = !shreg[7];
            end
        end
        else if (state == m_rdata)
            drive_low = (bit_cnt < 8) ? !shreg[7 - bit_cnt] : 1'b0;
        else if (state != m_idle && bit_cnt == 8)
        begin
            acking    = 1'b1;
            drive_low = 1'b1;
        end
    end

endmodule

// ==== eeprom_wr_tb.sv ====
`timescale 1ns/1ps

module eeprom_wr_tb;
    localparam int CLKS_PER_QUARTER = 2;
    localparam int TIMEOUT          = 2000;

    typedef struct packed {
        logic       is_read;
        logic [7:0] rdata;
        logic       nack;
    } exp_t;

    logic        CLK;
    logic        RESET;
    logic        wr;
    logic        rd;
    logic [10:0] addr;
    logic [7:0]  wdata;
    logic [7:0]  rdata;
    logic        ack;
    logic        nack;
    logic        scl;
    wire         sda;
    logic        present;

    logic [7:0]  shadow [0:2047];
    exp_t        exp_q [$];
    integer      seed = 59970;
    int          errors = 0;
    int          ack_count = 0;
    int          tests_failed = 0;
    int          test_start_errors = 0;

    pullup (sda);

    tb_clock_gen clk_i (
        .CLK   (CLK),
        .RESET (RESET)
    );

    eeprom_wr #(
        .CLKS_PER_QUARTER (CLKS_PER_QUARTER)
    ) dut_i (
        .CLK   (CLK),
        .RESET (RESET),
        .wr    (wr),
        .rd    (rd),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .ack   (ack),
        .nack  (nack),
        .scl   (scl),
        .sda   (sda)
    );

    eeprom_model model_i (
        .scl     (scl),
        .sda     (sda),
        .present (present)
    );

    function automatic logic [7:0] expected_read(input logic [10:0] a);
        return shadow[a];
    endfunction

    task automatic check_hex(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic abort_run(input string what);
        $display("ERROR: %s", what);
        $display("Simulation FAILED");
        $finish;
    endtask

    task automatic check_idle_pins();
        check_hex("scl", scl, 1'b1);
        check_hex("sda", sda, 1'b1);
        check_hex("ack", ack, 1'b0);
    endtask

    task automatic send_request(input logic is_wr, input logic [10:0] a,
                                input logic [7:0] d, input logic exp_nack);
        exp_t e;
        e.is_read = !is_wr;
        e.rdata   = expected_read(a);
        e.nack    = exp_nack;
        exp_q.push_back(e);
        if (is_wr && !exp_nack)
            shadow[a] = d;
        @(posedge CLK);
        wr    <= is_wr;
        rd    <= !is_wr;
        addr  <= a;
        wdata <= d;
        @(posedge CLK);
        wr <= 1'b0;
        rd <= 1'b0;
    endtask

    task automatic wait_ack();
        int n;
        n = 0;
        while (ack !== 1'b1 && n < TIMEOUT)
        begin
            @(posedge CLK);
            n++;
        end
        if (ack !== 1'b1)
            abort_run($sformatf("no ack within %0d cycles", TIMEOUT));
        else
            @(posedge CLK);   // single-cycle ack is low again here
    endtask

    task automatic run_request(input logic is_wr, input logic [10:0] a,
                               input logic [7:0] d, input logic exp_nack);
        send_request(is_wr, a, d, exp_nack);
        wait_ack();
    endtask

    task automatic compare_memory();
        for (int i = 0; i < 2048; i++)
            check_hex($sformatf("mem[0x%03h]", i), model_i.mem[i], shadow[i]);
    endtask

    task automatic end_test(input int num, input string name);
        int n;
        n = errors - test_start_errors;
        if (n == 0)
            $display("test %0d %s: ok", num, name);
        else
        begin
            $display("test %0d %s: bad, %0d errors", num, name, n);
            tests_failed++;
        end
        test_start_errors = errors;
    endtask

    // every ack is matched against the oldest outstanding request
    always @(posedge CLK)
    begin : compare_resp
        exp_t e;
        if (ack === 1'b1)
        begin
            ack_count++;
            assert (exp_q.size() > 0)
            else
            begin
                $display("ERROR: ack with no request outstanding");
                errors++;
            end
            if (exp_q.size() > 0)
            begin
                e = exp_q.pop_front();
                check_hex("nack", nack, e.nack);
                if (e.is_read && !e.nack)
                    check_hex("rdata", rdata, e.rdata);
            end
        end
    end

    initial
    begin : stimulus
        int          n;
        int          acks_before;
        logic [10:0] a;
        logic [7:0]  d;
        logic        w;
        logic [10:0] edge_addr [4];

        wr        = 1'b0;
        rd        = 1'b0;
        addr      = '0;
        wdata     = '0;
        present   = 1'b1;
        edge_addr = '{11'h000, 11'h0ff, 11'h100, 11'h7ff};
        for (int i = 0; i < 2048; i++)
        begin
            d              = 8'($random(seed));
            shadow[i]      = d;
            model_i.mem[i] = d;
        end

        @(posedge CLK);   // reset values land here
        n = 0;
        while (RESET === 1'b1 && n < 20)
        begin
            @(posedge CLK);
            check_idle_pins();
            n++;
        end
        if (RESET === 1'b1)
            abort_run("reset never released");
        repeat (3)
        begin
            @(posedge CLK);
            check_idle_pins();
        end
        end_test(1, "reset state");

        run_request(1'b1, 11'h2a5, ~expected_read(11'h2a5), 1'b0);
        run_request(1'b0, 11'h2a5, 8'h00, 1'b0);
        end_test(2, "write then read back");

        // first pairs hit the block-bit corners
        for (int i = 0; i < 40; i++)
        begin
            if (i < 8)
            begin
                a = edge_addr[i / 2];
                w = (i % 2 == 0);
            end
            else
            begin
                a = 11'($random(seed));
                w = 1'($random(seed));
            end
            d = 8'($random(seed));
            run_request(w, a, d, 1'b0);
        end
        compare_memory();
        end_test(3, "random traffic");

        a = 11'h3c1;
        @(posedge CLK);
        present <= 1'b0;
        run_request(1'b1, a, ~expected_read(a), 1'b1);
        run_request(1'b0, a, 8'h00, 1'b1);
        @(posedge CLK);
        present <= 1'b1;
        run_request(1'b0, a, 8'h00, 1'b0);
        end_test(4, "absent device");

        acks_before = ack_count;
        send_request(1'b1, 11'h155, 8'ha7, 1'b0);
        repeat (40) @(posedge CLK);
        wr    <= 1'b1;
        addr  <= 11'h6aa;
        wdata <= ~expected_read(11'h6aa);
        @(posedge CLK);
        wr <= 1'b0;
        repeat (40) @(posedge CLK);
        rd   <= 1'b1;
        addr <= 11'h155;
        @(posedge CLK);
        rd <= 1'b0;
        wait_ack();
        repeat (400) @(posedge CLK);   // room for a stray transaction to show up
        check_hex("ack count", ack_count - acks_before, 1);
        check_hex("scl", scl, 1'b1);
        compare_memory();
        end_test(5, "ignored strobes");

        $display("tests: 5 run, %0d failed, %0d errors, %0d acks",
                 tests_failed, errors, ack_count);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== list.f ====
eeprom_bus_pkg.sv
eeprom_host_pkg.sv
byte_shifter.sv
bit_engine.sv
eeprom_ctrl.sv
eeprom_wr.sv
tb_clock_gen.sv
eeprom_model.sv
eeprom_wr_tb.sv
